// ==== design/fft8_pkg.sv ====
`default_nettype none

package fft8_pkg;

    // ----------------------------------------------
    // transform size
    // ----------------------------------------------
    localparam int N_POINTS = 8;             // points per frame
    localparam int LOG2_N   = 3;             // radix-2 stages
    localparam int N_BFLY   = N_POINTS / 2;  // butterflies per stage

    // ----------------------------------------------
    // fixed point
    // ----------------------------------------------
    localparam int SAMPLE_W = 16;  // re / im part of a sample
    localparam int PROD_W   = 32;  // products and butterfly sums
    localparam int FRAC_W   = 13;  // twiddle fraction bits, also the output shift

    // ----------------------------------------------
    // twiddles W8^k, k = 0..3, in Q13
    // ----------------------------------------------
    // W8^k = cos(2*pi*k/8) - j*sin(2*pi*k/8)
    // 5793 is round(8192 / sqrt(2))
    localparam logic signed [SAMPLE_W-1:0] TW_RE [N_BFLY] = '{
        16'sd8192,   // k = 0
        16'sd5793,   // k = 1
        16'sd0,      // k = 2
        -16'sd5793   // k = 3
    };

    localparam logic signed [SAMPLE_W-1:0] TW_IM [N_BFLY] = '{
        16'sd0,      // k = 0
        -16'sd5793,  // k = 1
        -16'sd8192,  // k = 2
        -16'sd5793   // k = 3
    };

endpackage

`default_nettype wire

// ==== design/butterfly.sv ====
`timescale 1ns/1ps
`default_nettype none

module butterfly (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                en,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] xp_re,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] xp_im,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] xq_re,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] xq_im,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] factor_re,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] factor_im,
    output logic                                vld,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] yp_re,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] yp_im,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] yq_re,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] yq_im
);
    import fft8_pkg::*;

    logic [2:0] en_q;  // enable delayed by 1, 2, 3 cycles

    // stage 1 registers
    logic signed [PROD_W-1:0] p_rr;  // xq_re * w_re
    logic signed [PROD_W-1:0] p_ii;  // xq_im * w_im
    logic signed [PROD_W-1:0] p_ri;  // xq_re * w_im
    logic signed [PROD_W-1:0] p_ir;  // xq_im * w_re
    logic signed [PROD_W-1:0] xp_re_s1;
    logic signed [PROD_W-1:0] xp_im_s1;

    // stage 2 registers
    logic signed [PROD_W-1:0] xqw_re;
    logic signed [PROD_W-1:0] xqw_im;
    logic signed [PROD_W-1:0] xp_re_s2;
    logic signed [PROD_W-1:0] xp_im_s2;

    // stage 3 registers
    logic signed [PROD_W-1:0] sum_re;
    logic signed [PROD_W-1:0] sum_im;
    logic signed [PROD_W-1:0] dif_re;
    logic signed [PROD_W-1:0] dif_im;

    // ----------------------------------------------
    // valid pipeline
    // ----------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= '0;
        end else begin
            en_q <= {en_q[1:0], en};
        end
    end

    assign vld = en_q[2];  // 3 cycles after en, same cycle as the result

    // ----------------------------------------------
    // cycle 1: partial products, xp aligned to Q13
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (en) begin
            p_rr     <= xq_re * factor_re;
            p_ii     <= xq_im * factor_im;
            p_ri     <= xq_re * factor_im;
            p_ir     <= xq_im * factor_re;
            xp_re_s1 <= PROD_W'(xp_re) <<< FRAC_W;  // sign extended, then shifted
            xp_im_s1 <= PROD_W'(xp_im) <<< FRAC_W;
        end
    end

    // ----------------------------------------------
    // cycle 2: xq * W
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (en_q[0]) begin
            xqw_re   <= p_rr - p_ii;
            xqw_im   <= p_ri + p_ir;
            xp_re_s2 <= xp_re_s1;
            xp_im_s2 <= xp_im_s1;
        end
    end

    // ----------------------------------------------
    // cycle 3: sum and difference
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (en_q[1]) begin
            sum_re <= xp_re_s2 + xqw_re;
            sum_im <= xp_im_s2 + xqw_im;
            dif_re <= xp_re_s2 - xqw_re;
            dif_im <= xp_im_s2 - xqw_im;
        end
    end

    // back to Q0, bits 28:13, truncating
    assign yp_re = sum_re[SAMPLE_W+FRAC_W-1:FRAC_W];
    assign yp_im = sum_im[SAMPLE_W+FRAC_W-1:FRAC_W];
    assign yq_re = dif_re[SAMPLE_W+FRAC_W-1:FRAC_W];
    assign yq_im = dif_im[SAMPLE_W+FRAC_W-1:FRAC_W];

endmodule

`default_nettype wire

// ==== design/fft8_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft8_loader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] in_re,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] in_im,
    output logic                                frame_valid,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] frame_re [fft8_pkg::N_POINTS],
    output logic signed [fft8_pkg::SAMPLE_W-1:0] frame_im [fft8_pkg::N_POINTS]
);
    import fft8_pkg::*;

    logic [2:0]                 cnt;        // slot of the next sample
    logic                       frame_done; // eighth sample taken last edge
    logic signed [SAMPLE_W-1:0] col_re [N_POINTS-1];  // first seven samples
    logic signed [SAMPLE_W-1:0] col_im [N_POINTS-1];

    // 3-bit index reversal, 8 points only
    function automatic logic [2:0] bit_rev(input logic [2:0] v);
        return {v[0], v[1], v[2]};
    endfunction

    // ----------------------------------------------
    // sample counter and frame strobe
    // ----------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;   // partial frame is dropped
            frame_done  <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_done  <= in_valid && (cnt == 3'd7);
            frame_valid <= frame_done;               // one cycle after the bank write
            if (in_valid) begin
                cnt <= cnt + 3'd1;                   // wraps to 0 after sample 7
            end
        end
    end

    // ----------------------------------------------
    // collection buffer
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid && (cnt != 3'd7)) begin
            col_re[cnt] <= in_re;
            col_im[cnt] <= in_im;
        end
    end

    // ----------------------------------------------
    // output bank, written in bit-reversed order
    // ----------------------------------------------
    // held until the next frame completes, at least 8 cycles later
    always_ff @(posedge clk) begin
        if (in_valid && (cnt == 3'd7)) begin
            for (int i = 0; i < N_POINTS - 1; i++) begin
                frame_re[bit_rev(3'(i))] <= col_re[i];
                frame_im[bit_rev(3'(i))] <= col_im[i];
            end
            frame_re[N_POINTS-1] <= in_re;  // index 7 reverses to itself
            frame_im[N_POINTS-1] <= in_im;
        end
    end

endmodule

`default_nettype wire

// ==== design/fft8_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft8_stage #(
    parameter int STAGE = 0  // 0 .. LOG2_N-1
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] in_re  [fft8_pkg::N_POINTS],
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] in_im  [fft8_pkg::N_POINTS],
    output logic                                out_valid,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] out_re [fft8_pkg::N_POINTS],
    output logic signed [fft8_pkg::SAMPLE_W-1:0] out_im [fft8_pkg::N_POINTS]
);
    import fft8_pkg::*;

    logic bf_vld [N_BFLY];  // all equal, shared en

    // ----------------------------------------------
    // four butterflies, in-place DIT wiring
    // ----------------------------------------------
    for (genvar k = 0; k < N_BFLY; k++) begin : g_bfly
        localparam int SPAN = 1 << STAGE;              // distance p to q
        localparam int J    = k % SPAN;                // position in the group
        localparam int P    = (k / SPAN) * 2 * SPAN + J;
        localparam int Q    = P + SPAN;
        localparam int TW   = J << (LOG2_N - 1 - STAGE);  // twiddle power of W8

        butterfly u_bfly (
            .clk       (clk),
            .rst_n     (rst_n),
            .en        (in_valid),
            .xp_re     (in_re[P]),
            .xp_im     (in_im[P]),
            .xq_re     (in_re[Q]),
            .xq_im     (in_im[Q]),
            .factor_re (TW_RE[TW]),
            .factor_im (TW_IM[TW]),
            .vld       (bf_vld[k]),
            .yp_re     (out_re[P]),   // results go back to the same slots
            .yp_im     (out_im[P]),
            .yq_re     (out_re[Q]),
            .yq_im     (out_im[Q])
        );
    end

    // butterflies finish together
    assign out_valid = bf_vld[0];

endmodule

`default_nettype wire

// ==== design/fft8_unloader.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft8_unloader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                frame_valid,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] frame_re [fft8_pkg::N_POINTS],
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] frame_im [fft8_pkg::N_POINTS],
    output logic                                out_valid,
    output logic [2:0]                          out_index,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] out_re,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] out_im
);
    import fft8_pkg::*;

    logic                       busy;  // bins still being sent
    logic [2:0]                 idx;   // bin on the output now
    logic signed [SAMPLE_W-1:0] hold_re [N_POINTS];
    logic signed [SAMPLE_W-1:0] hold_im [N_POINTS];

    // ----------------------------------------------
    // frame capture
    // ----------------------------------------------
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            hold_re <= frame_re;
            hold_im <= frame_im;
        end
    end

    // ----------------------------------------------
    // serial output control
    // ----------------------------------------------
    // a new frame on the last bin's edge restarts cleanly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (frame_valid) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            idx <= idx + 3'd1;
            if (idx == 3'd7) begin
                busy <= 1'b0;  // all eight bins sent
            end
        end
    end

    assign out_valid = busy;
    assign out_index = idx;
    assign out_re    = hold_re[idx];
    assign out_im    = hold_im[idx];

endmodule

`default_nettype wire

// ==== design/fft8_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft8_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] in_re,
    input  logic signed [fft8_pkg::SAMPLE_W-1:0] in_im,
    output logic                                out_valid,
    output logic [2:0]                          out_index,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] out_re,
    output logic signed [fft8_pkg::SAMPLE_W-1:0] out_im
);
    import fft8_pkg::*;

    // ----------------------------------------------
    // stage to stage frames
    // ----------------------------------------------
    // index 0 from the loader, LOG2_N into the unloader
    logic                       st_valid [LOG2_N+1];
    logic signed [SAMPLE_W-1:0] st_re    [LOG2_N+1][N_POINTS];
    logic signed [SAMPLE_W-1:0] st_im    [LOG2_N+1][N_POINTS];

    // serial in, bit-reversed frame out
    fft8_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_re       (in_re),
        .in_im       (in_im),
        .frame_valid (st_valid[0]),
        .frame_re    (st_re[0]),
        .frame_im    (st_im[0])
    );

    // ----------------------------------------------
    // butterfly stages, 3 cycles each
    // ----------------------------------------------
    for (genvar s = 0; s < LOG2_N; s++) begin : g_stage
        fft8_stage #(
            .STAGE (s)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (st_valid[s]),
            .in_re     (st_re[s]),
            .in_im     (st_im[s]),
            .out_valid (st_valid[s+1]),
            .out_re    (st_re[s+1]),
            .out_im    (st_im[s+1])
        );
    end

    // bins out in natural order
    fft8_unloader u_unloader (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (st_valid[LOG2_N]),
        .frame_re    (st_re[LOG2_N]),
        .frame_im    (st_im[LOG2_N]),
        .out_valid   (out_valid),
        .out_index   (out_index),
        .out_re      (out_re),
        .out_im      (out_im)
    );

endmodule

`default_nettype wire

// ==== include/fft8_tb_util.svh ====
`ifndef FFT8_TB_UTIL_SVH
`define FFT8_TB_UTIL_SVH

// ----------------------------------------------
// 16-bit Fibonacci LFSR, taps 16 14 13 11
// ----------------------------------------------
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// 11 bits, one step per bit, folded onto -1000 .. +1000
function automatic int lfsr_sample(inout logic [15:0] s);
    int v;
    v = 0;
    for (int b = 0; b < 11; b++) begin
        s = lfsr_step(s);
        v = (v << 1) | int'(s[0]);
    end
    return (v % 2001) - 1000;
endfunction

// ----------------------------------------------
// bit-exact 8-point DIT model
// ----------------------------------------------
function automatic void ref_fft8(
    input  logic signed [15:0] x_re [8],
    input  logic signed [15:0] x_im [8],
    output logic signed [15:0] y_re [8],
    output logic signed [15:0] y_im [8]
);
    logic signed [15:0] a_re [8];
    logic signed [15:0] a_im [8];
    logic signed [31:0] q_re;   // xq, sign extended
    logic signed [31:0] q_im;
    logic signed [31:0] c_re;   // twiddle, sign extended
    logic signed [31:0] c_im;
    logic signed [31:0] w_re;   // xq * W in Q13
    logic signed [31:0] w_im;
    logic signed [31:0] xp_re;  // xp aligned to Q13
    logic signed [31:0] xp_im;
    int                 span;
    int                 p;
    int                 q;
    int                 tw;
    for (int i = 0; i < 8; i++) begin
        a_re[{i[0], i[1], i[2]}] = x_re[i];  // bit-reversed load
        a_im[{i[0], i[1], i[2]}] = x_im[i];
    end
    for (int s = 0; s < 3; s++) begin
        span = 1 << s;
        for (int k = 0; k < 4; k++) begin
            p = (k / span) * 2 * span + (k % span);
            q = p + span;
            tw = (k % span) << (2 - s);
            q_re = a_re[q];
            q_im = a_im[q];
            c_re = fft8_pkg::TW_RE[tw];
            c_im = fft8_pkg::TW_IM[tw];
            w_re = q_re * c_re - q_im * c_im;  // full 32-bit products
            w_im = q_re * c_im + q_im * c_re;
            xp_re = 32'(a_re[p]) <<< 13;
            xp_im = 32'(a_im[p]) <<< 13;
            a_re[p] = 16'((xp_re + w_re) >>> 13);
            a_im[p] = 16'((xp_im + w_im) >>> 13);
            a_re[q] = 16'((xp_re - w_re) >>> 13);
            a_im[q] = 16'((xp_im - w_im) >>> 13);
        end
    end
    y_re = a_re;
    y_im = a_im;
endfunction

`endif

// ==== verification/fft8_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fft8_tb;
    import fft8_pkg::*;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    logic signed [SAMPLE_W-1:0] in_re;
    logic signed [SAMPLE_W-1:0] in_im;
    logic                       out_valid;
    logic [2:0]                 out_index;
    logic signed [SAMPLE_W-1:0] out_re;
    logic signed [SAMPLE_W-1:0] out_im;

    logic [15:0]        lfsr;           // stimulus state
    logic signed [15:0] exp_re_q [$];   // bins still owed by the DUT, oldest first
    logic signed [15:0] exp_im_q [$];
    logic [2:0]         exp_idx_q [$];
    int                 err_cnt;
    int                 chk_cnt;
    int                 bins_seen;      // every out_valid cycle outside reset
    int                 test_cnt;
    int                 fail_cnt;
    int                 test_err0;      // err_cnt when the current test began

    `include "fft8_tb_util.svh"

    fft8_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (out_valid),
        .out_index (out_index),
        .out_re    (out_re),
        .out_im    (out_im)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // --------------------------------------------------
    // output monitor, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            bins_seen++;
            chk_cnt++;
            assert (exp_re_q.size() > 0) else begin
                $display("unexpected output: bin %0d came out at %0t with no frame pending",
                         out_index, $time);
                err_cnt++;
            end
            if (exp_re_q.size() > 0) begin
                chk_cnt++;
                assert (out_index == exp_idx_q[0] && out_re == exp_re_q[0]
                        && out_im == exp_im_q[0]) else begin
                    $display("mismatch at %0t: bin %0d expected %0d %0dj, got bin %0d %0d %0dj",
                             $time, exp_idx_q[0], exp_re_q[0], exp_im_q[0],
                             out_index, out_re, out_im);
                    err_cnt++;
                end
                void'(exp_re_q.pop_front());
                void'(exp_im_q.pop_front());
                void'(exp_idx_q.pop_front());
            end
        end
    end

    // n bits, one LFSR step each
    function automatic int lfsr_take(inout logic [15:0] s, input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            s = lfsr_step(s);
            v = (v << 1) | int'(s[0]);
        end
        return v;
    endfunction

    function automatic void random_frame(output logic signed [15:0] re [8],
                                         output logic signed [15:0] im [8]);
        for (int i = 0; i < 8; i++) begin
            re[i] = 16'(lfsr_sample(lfsr));  // re before im, sample by sample
            im[i] = 16'(lfsr_sample(lfsr));
        end
    endfunction

    // --------------------------------------------------
    // stimulus helpers, all driving on the falling edge
    // --------------------------------------------------
    task automatic drive_idle();
        @(negedge clk);
        in_valid = 1'b0;
        in_re    = '0;
        in_im    = '0;
    endtask

    task automatic drive_sample(input logic signed [15:0] re, input logic signed [15:0] im);
        @(negedge clk);
        in_valid = 1'b1;
        in_re    = re;
        in_im    = im;
    endtask

    // gapped: 0..3 idle cycles from the LFSR before each sample
    task automatic send_samples(input logic signed [15:0] re [8],
                                input logic signed [15:0] im [8], input bit gapped);
        int gap;
        for (int i = 0; i < 8; i++) begin
            if (gapped) begin
                gap = lfsr_take(lfsr, 2);
                repeat (gap) drive_idle();
            end
            drive_sample(re[i], im[i]);
        end
    endtask

    task automatic queue_bins(input logic signed [15:0] re [8], input logic signed [15:0] im [8]);
        for (int b = 0; b < 8; b++) begin
            exp_re_q.push_back(re[b]);
            exp_im_q.push_back(im[b]);
            exp_idx_q.push_back(3'(b));  // natural bin order
        end
    endtask

    // model the frame, then send it
    task automatic send_modeled(input logic signed [15:0] re [8],
                                input logic signed [15:0] im [8], input bit gapped);
        logic signed [15:0] y_re [8];
        logic signed [15:0] y_im [8];
        ref_fft8(re, im, y_re, y_im);
        queue_bins(y_re, y_im);
        send_samples(re, im, gapped);
    endtask

    // --------------------------------------------------
    // waits and test bookkeeping
    // --------------------------------------------------
    // started on the falling edge just after the edge that takes the last sample
    task automatic check_latency(input int want);
        int lat;
        lat = 0;  // rising edges since that edge
        while (!out_valid && lat < 50) begin
            @(negedge clk);
            lat++;
        end
        if (!out_valid) begin
            $display("timeout: no output bin within 50 cycles of the last sample");
            err_cnt++;
        end else begin
            chk_cnt++;
            assert (lat == want) else begin
                $display("mismatch at %0t: first bin after %0d cycles, expected %0d",
                         $time, lat, want);
                err_cnt++;
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_re_q.size() != 0 && cycles < 50) begin
            @(posedge clk);  // monitor pops on negedge, no race
            cycles++;
        end
        if (exp_re_q.size() != 0) begin
            $display("timeout: %0d output bins did not appear within 50 cycles", exp_re_q.size());
            err_cnt++;
            exp_re_q.delete();
            exp_im_q.delete();
            exp_idx_q.delete();
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            chk_cnt++;
            assert (!out_valid) else begin
                $display("mismatch at %0t: out_valid is 1, expected 0", $time);
                err_cnt++;
            end
        end
    endtask

    task automatic start_test();
        test_err0 = err_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %0s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %0s: failed with %0d errors", name, err_cnt - test_err0);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic signed [15:0] fr_re [8];
        logic signed [15:0] fr_im [8];
        logic signed [15:0] y_re [8];
        logic signed [15:0] y_im [8];
        int                 seen0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_re     = '0;
        in_im     = '0;
        lfsr      = 16'd51735;
        err_cnt   = 0;
        chk_cnt   = 0;
        bins_seen = 0;
        test_cnt  = 0;
        fail_cnt  = 0;

        start_test();
        check_quiet(5);      // 5 cycles in reset
        rst_n = 1'b1;        // released on a falling edge
        check_quiet(20);
        end_test("reset");

        start_test();
        for (int i = 0; i < 8; i++) begin
            fr_re[i] = '0;
            fr_im[i] = '0;
            y_re[i]  = 16'sd1000;  // flat spectrum
            y_im[i]  = '0;
        end
        fr_re[0] = 16'sd1000;
        queue_bins(y_re, y_im);
        send_samples(fr_re, fr_im, 1'b0);
        drive_idle();
        check_latency(11);   // 1 loader, 9 stages, 1 unloader
        wait_drain();
        end_test("impulse");

        start_test();
        for (int i = 0; i < 8; i++) begin
            fr_re[i] = 16'sd500;
            fr_im[i] = -16'sd300;
        end
        ref_fft8(fr_re, fr_im, y_re, y_im);
        y_re[0] = 16'sd4000;   // 8 x (500 - 300j), exact
        y_im[0] = -16'sd2400;
        queue_bins(y_re, y_im);
        send_samples(fr_re, fr_im, 1'b0);
        drive_idle();
        wait_drain();
        end_test("dc");

        start_test();
        repeat (20) begin          // in_valid never drops between frames
            random_frame(fr_re, fr_im);
            send_modeled(fr_re, fr_im, 1'b0);
        end
        drive_idle();
        wait_drain();
        end_test("back_to_back");

        start_test();
        repeat (5) begin
            random_frame(fr_re, fr_im);
            send_modeled(fr_re, fr_im, 1'b1);
        end
        drive_idle();
        wait_drain();
        end_test("gapped");

        start_test();
        repeat (3) begin           // partial frame, lost in reset
            drive_sample(16'(lfsr_sample(lfsr)), 16'(lfsr_sample(lfsr)));
        end
        drive_idle();
        rst_n = 1'b0;
        @(negedge clk);
        rst_n = 1'b1;
        seen0 = bins_seen;
        random_frame(fr_re, fr_im);
        send_modeled(fr_re, fr_im, 1'b0);
        drive_idle();
        wait_drain();
        check_quiet(20);           // nothing after the 8 bins
        chk_cnt++;
        assert (bins_seen - seen0 == 8) else begin
            $display("mismatch at %0t: %0d bins after reset, expected 8", $time,
                     bins_seen - seen0);
            err_cnt++;
        end
        end_test("reset_mid_frame");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, fail_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fft8_core.f ====
+incdir+include
design/fft8_pkg.sv
design/butterfly.sv
design/fft8_loader.sv
design/fft8_stage.sv
design/fft8_unloader.sv
design/fft8_core.sv
verification/fft8_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fft8 testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module fft8_tb -f fft8_core.f -o fft8_sim \
    && ./obj_dir/fft8_sim > sim.log 2>&1 \
    || echo "build or run did not complete"

cat sim.log 2>/dev/null
grep -q "^No errors$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
